// File: vlog.f
verilog/pdp8_types_pkg.sv
verilog/pdp8_isa_pkg.sv
verilog/ifd_fetch_ctrl.sv
verilog/ifd_decoder.sv
verilog/ifd_top.sv
bench/ifd_properties.sv
bench/tb_ifd.sv

// File: Makefile
TOP := tb_ifd

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f vlog.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f vlog.f
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "all tests passed"

clean:
	rm -rf obj_dir

// File: bench/tb_ifd.sv
/*
   Testbench for the PDP-8 fetch and decode unit
   Memory and execution-unit models run a straight-line program that
   covers every decode class, with random stalls between fetches.
   The bound assertions do the checking.
*/
`timescale 1ns/100ps

module tb_ifd;

   import pdp8_types_pkg::*;

   localparam addr_t start_addr  = 12'o200;
   localparam int    prog_len    = 30;
   localparam int    cycle_limit = 40;

   // Memory-reference words and the 22 operate codes, then IOT and an unlisted operate word
   localparam word_t program_words [prog_len] = '{
      12'o0123, 12'o1377, 12'o2400, 12'o3055, 12'o4777, 12'o5201,
      12'o7000, 12'o7001, 12'o7004, 12'o7006, 12'o7010, 12'o7012,
      12'o7020, 12'o7040, 12'o7041, 12'o7100, 12'o7200, 12'o7300,
      12'o7402, 12'o7404, 12'o7410, 12'o7420, 12'o7430, 12'o7440,
      12'o7450, 12'o7500, 12'o7510, 12'o7600, 12'o6031, 12'o7777
   };

   logic    clk;
   logic    rst;
   logic    stall;
   addr_t   pc_value;
   word_t   rd_data;
   logic    rd_req;
   addr_t   rd_addr;
   mem_op_t mem_op;
   op7_op_t op7_op;
   offset_t mem_offset;
   logic    unsupported;
   logic    dec_valid;

   word_t   mem [4096];
   integer  seed;
   int      dec_count;
   int      stall_cycles;
   int      tests_run;
   int      tests_failed;
   int      fails_before;

   ifd_top #(
      .start_addr (start_addr)
   ) u_dut (
      .clk         (clk),
      .rst         (rst),
      .stall       (stall),
      .pc_value    (pc_value),
      .rd_data     (rd_data),
      .rd_req      (rd_req),
      .rd_addr     (rd_addr),
      .mem_op      (mem_op),
      .op7_op      (op7_op),
      .mem_offset  (mem_offset),
      .unsupported (unsupported),
      .dec_valid   (dec_valid)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // ------------------------------------------------------------------
   // Memory model answering on the cycle after the request
   // ------------------------------------------------------------------
   initial begin : memory_model
      logic  pending;
      addr_t pending_addr;
      pending      = 1'b0;
      pending_addr = '0;
      rd_data      = '0;
      for (int a = 0; a < 4096; a++) begin
         mem[a] = word_t'(a) ^ 12'o5252;
      end
      for (int i = 0; i < prog_len; i++) begin
         mem[start_addr + addr_t'(i)] = program_words[i];
      end
      forever begin
         @(posedge clk);
         #1;
         if (pending) begin
            rd_data = mem[pending_addr];
         end
         pending      = rd_req;
         pending_addr = rd_addr;
      end
   end

   // ------------------------------------------------------------------
   // Execution unit model
   // ------------------------------------------------------------------
   initial begin : exec_model
      logic respond;
      int   stall_left;
      respond      = 1'b0;
      stall_left   = 0;
      stall        = 1'b0;
      pc_value     = '0;
      seed         = 32'hdde7;
      dec_count    = 0;
      stall_cycles = 0;
      forever begin
         @(posedge clk);
         #1;
         if (respond) begin
            // Sequential program that wraps to the entry point after the last word
            if (dec_count == prog_len) begin
               pc_value = start_addr;
            end else begin
               pc_value = start_addr + addr_t'(dec_count);
            end
            stall_left = $unsigned($random(seed)) % 5;
            respond    = 1'b0;
         end else if (stall_left > 0) begin
            stall_left = stall_left - 1;
         end
         stall = (stall_left != 0);
         if (stall) begin
            stall_cycles++;
         end
         if (dec_valid) begin
            dec_count++;
            respond = 1'b1;
         end
      end
   end

   task automatic wait_first_read(output bit timed_out);
      int cycles;
      cycles    = 0;
      timed_out = 1'b0;
      while (!rd_req && !timed_out) begin
         @(posedge clk);
         #2;
         cycles++;
         if (cycles > 20) begin
            timed_out = 1'b1;
         end
      end
   endtask

   task automatic wait_decodes(input int target, input int limit, output bit timed_out);
      int cycles;
      cycles    = 0;
      timed_out = 1'b0;
      while (dec_count < target && !timed_out) begin
         @(posedge clk);
         #2;
         cycles++;
         if (cycles > limit) begin
            timed_out = 1'b1;
         end
      end
   endtask

   // Result line of one test once the edge after its last event is checked
   task automatic finish_test(input string name, input bit problem, input string what);
      int new_fails;
      @(posedge clk);
      #2;
      new_fails    = u_dut.u_props.fail_count - fails_before;
      fails_before = u_dut.u_props.fail_count;
      tests_run++;
      if (problem) begin
         tests_failed++;
         $display("test %0d %s: %s", tests_run, name, what);
      end else if (new_fails != 0) begin
         tests_failed++;
         $display("** Error at %0t: test %0d %s, %0d assertion failures",
                  $time, tests_run, name, new_fails);
      end else begin
         $display("test %0d %s: pass", tests_run, name);
      end
   endtask

   initial begin : test_sequence
      bit timed_out;
      tests_run    = 0;
      tests_failed = 0;
      fails_before = 0;
      rst          = 1'b1;
      repeat (5) @(posedge clk);
      #1;
      rst = 1'b0;

      wait_first_read(timed_out);
      finish_test("reset and first read", timed_out, "no read request after reset");
      wait_decodes(6, 6 * cycle_limit, timed_out);
      finish_test("memory-reference decode", timed_out, "timed out waiting for dec_valid");
      wait_decodes(28, 22 * cycle_limit, timed_out);
      finish_test("operate decode", timed_out, "timed out waiting for dec_valid");
      wait_decodes(prog_len, 2 * cycle_limit, timed_out);
      finish_test("unsupported words", timed_out, "timed out waiting for dec_valid");
      finish_test("outputs hold in stall", stall_cycles == 0, "no stall period was seen");

      // Observation window after the PC wraps to the start address
      repeat (cycle_limit) @(posedge clk);
      #2;
      finish_test("program end", !u_dut.u_props.ended, "program end was not reached");

      $display("summary: %0d tests run, %0d passed, %0d failed",
               tests_run, tests_run - tests_failed, tests_failed);
      if (tests_failed == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

// File: bench/ifd_properties.sv
/*
   Fetch and decode checks
   Concurrent assertions bound to the fetch and decode unit. Reset
   values, read strobes, decode latency, decode results, output hold
   and the end of program are checked against a local rule table.
*/
`timescale 1ns/100ps

module ifd_properties #(
   parameter pdp8_types_pkg::addr_t start_addr = 12'o200
) (
   input logic                    clk,
   input logic                    rst,
   input logic                    stall,
   input pdp8_types_pkg::addr_t   pc_value,
   input pdp8_types_pkg::word_t   rd_data,
   input logic                    rd_req,
   input pdp8_types_pkg::addr_t   rd_addr,
   input pdp8_types_pkg::mem_op_t mem_op,
   input pdp8_types_pkg::op7_op_t op7_op,
   input pdp8_types_pkg::offset_t mem_offset,
   input logic                    unsupported,
   input logic                    dec_valid
);

   import pdp8_types_pkg::*;

   // Operate codes indexed by their op7_op bit
   localparam word_t op7_codes [op7_op_w] = '{
      12'o7000, 12'o7001, 12'o7004, 12'o7006, 12'o7010, 12'o7012,
      12'o7020, 12'o7040, 12'o7041, 12'o7100, 12'o7200, 12'o7300,
      12'o7402, 12'o7404, 12'o7410, 12'o7420, 12'o7430, 12'o7440,
      12'o7450, 12'o7500, 12'o7510, 12'o7600
   };

   logic [2:0] major;
   mem_op_t    rule_mem_op;
   op7_op_t    rule_op7_op;
   offset_t    rule_offset;
   logic       rule_unsup;
   mem_op_t    exp_mem_op;
   op7_op_t    exp_op7_op;
   offset_t    exp_offset;
   logic       exp_unsup;
   logic       data_cycle;
   logic       wait_phase;
   logic       ended;
   int         fail_count = 0;

   assign major = rd_data[11:9];

   // ------------------------------------------------------------------
   // Rule table applied to the word on the memory bus
   // ------------------------------------------------------------------
   always_comb begin
      rule_mem_op = '0;
      rule_op7_op = '0;
      rule_offset = '0;
      rule_unsup  = 1'b0;
      if (major <= 3'd5) begin
         rule_mem_op[major] = 1'b1;
         rule_offset        = rd_data[8:0];
      end else begin
         for (int i = 0; i < op7_op_w; i++) begin
            if (rd_data == op7_codes[i]) begin
               rule_op7_op[i] = 1'b1;
            end
         end
         // IOT and unlisted operate words fall back to NOP
         if (rule_op7_op == '0) begin
            rule_op7_op[0] = 1'b1;
            rule_unsup     = 1'b1;
         end
      end
   end

   // Expected outputs and the wait for the execution unit
   always_ff @(posedge clk) begin
      if (rst) begin
         data_cycle <= 1'b0;
         wait_phase <= 1'b0;
         ended      <= 1'b0;
         exp_mem_op <= '0;
         exp_op7_op <= '0;
         exp_offset <= '0;
         exp_unsup  <= 1'b0;
      end else begin
         data_cycle <= rd_req;
         if (data_cycle) begin
            exp_mem_op <= rule_mem_op;
            exp_op7_op <= rule_op7_op;
            exp_offset <= rule_offset;
            exp_unsup  <= rule_unsup;
         end
         if (dec_valid) begin
            wait_phase <= 1'b1;
         end else if (wait_phase && !stall) begin
            wait_phase <= 1'b0;
         end
         if (wait_phase && !stall && pc_value == start_addr) begin
            ended <= 1'b1;
         end
      end
   end

   // ------------------------------------------------------------------
   // Assertions
   // ------------------------------------------------------------------
   reset_clears_outputs: assert property (@(posedge clk)
      rst |=> (!rd_req && rd_addr == '0 && !dec_valid && mem_op == '0 &&
               op7_op == '0 && mem_offset == '0 && !unsupported))
   else begin
      $error("outputs not cleared by reset");
      fail_count++;
   end

   first_read_at_start: assert property (@(posedge clk)
      $fell(rst) |=> (rd_req && rd_addr == start_addr))
   else begin
      $error("first read missing or not at the start address");
      fail_count++;
   end

   read_is_pulse: assert property (@(posedge clk) disable iff (rst)
      rd_req |=> !rd_req)
   else begin
      $error("rd_req longer than one cycle");
      fail_count++;
   end

   no_read_in_stall: assert property (@(posedge clk) disable iff (rst)
      rd_req |-> !stall)
   else begin
      $error("rd_req while stall is high");
      fail_count++;
   end

   next_read_from_pc: assert property (@(posedge clk) disable iff (rst)
      (wait_phase && !stall && pc_value != start_addr) |=>
         (rd_req && rd_addr == $past(pc_value)))
   else begin
      $error("next read missing or not at pc_value");
      fail_count++;
   end

   decode_two_cycles: assert property (@(posedge clk) disable iff (rst)
      rd_req |-> ##2 dec_valid)
   else begin
      $error("dec_valid not two cycles after rd_req");
      fail_count++;
   end

   decode_has_read: assert property (@(posedge clk) disable iff (rst)
      dec_valid |-> $past(rd_req, 2))
   else begin
      $error("dec_valid without a read two cycles before");
      fail_count++;
   end

   decode_matches_rules: assert property (@(posedge clk) disable iff (rst)
      dec_valid |-> (mem_op == exp_mem_op && op7_op == exp_op7_op &&
                     mem_offset == exp_offset && unsupported == exp_unsup))
   else begin
      $error("decoded outputs differ from the decode rules");
      fail_count++;
   end

   single_decode_bit: assert property (@(posedge clk) disable iff (rst)
      $onehot0({mem_op, op7_op}))
   else begin
      $error("more than one decode bit set");
      fail_count++;
   end

   outputs_hold: assert property (@(posedge clk) disable iff (rst)
      !dec_valid |-> $stable({mem_op, op7_op, mem_offset, unsupported}))
   else begin
      $error("decoded outputs changed without dec_valid");
      fail_count++;
   end

   no_fetch_after_end: assert property (@(posedge clk) disable iff (rst)
      ended |-> !rd_req)
   else begin
      $error("read issued after the program ended");
      fail_count++;
   end

endmodule

bind ifd_top ifd_properties #(
   .start_addr (start_addr)
) u_props (
   .clk         (clk),
   .rst         (rst),
   .stall       (stall),
   .pc_value    (pc_value),
   .rd_data     (rd_data),
   .rd_req      (rd_req),
   .rd_addr     (rd_addr),
   .mem_op      (mem_op),
   .op7_op      (op7_op),
   .mem_offset  (mem_offset),
   .unsupported (unsupported),
   .dec_valid   (dec_valid)
);

// File: verilog/ifd_top.sv
/*
   PDP-8 instruction fetch and decode unit
   Fetch sequencer feeding the decoder, with one instruction in
   flight and the execution unit pacing fetches through stall
*/
`timescale 1ns/100ps

module ifd_top #(
   parameter pdp8_types_pkg::addr_t start_addr = 12'o200
) (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    stall,
   input  pdp8_types_pkg::addr_t   pc_value,
   input  pdp8_types_pkg::word_t   rd_data,
   output logic                    rd_req,
   output pdp8_types_pkg::addr_t   rd_addr,
   output pdp8_types_pkg::mem_op_t mem_op,
   output pdp8_types_pkg::op7_op_t op7_op,
   output pdp8_types_pkg::offset_t mem_offset,
   output logic                    unsupported,
   output logic                    dec_valid
);

   // Read data qualifier from sequencer to decoder
   logic data_valid;

   ifd_fetch_ctrl #(
      .start_addr (start_addr)
   ) u_fetch_ctrl (
      .clk        (clk),
      .rst        (rst),
      .stall      (stall),
      .pc_value   (pc_value),
      .rd_req     (rd_req),
      .rd_addr    (rd_addr),
      .data_valid (data_valid)
   );

   ifd_decoder u_decoder (
      .clk         (clk),
      .rst         (rst),
      .data_valid  (data_valid),
      .rd_data     (rd_data),
      .mem_op      (mem_op),
      .op7_op      (op7_op),
      .mem_offset  (mem_offset),
      .unsupported (unsupported),
      .dec_valid   (dec_valid)
   );

endmodule

// File: verilog/ifd_decoder.sv
/*
   Instruction decoder
   Splits the fetched word into a one-hot memory-reference vector or a
   one-hot operate vector, keeps the page offset and flags words the
   execution unit cannot run. Results are registered when the read
   data is valid and hold until the next instruction.
*/
`timescale 1ns/100ps

module ifd_decoder (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    data_valid,
   input  pdp8_types_pkg::word_t   rd_data,
   output pdp8_types_pkg::mem_op_t mem_op,
   output pdp8_types_pkg::op7_op_t op7_op,
   output pdp8_types_pkg::offset_t mem_offset,
   output logic                    unsupported,
   output logic                    dec_valid
);

   import pdp8_types_pkg::*;
   import pdp8_isa_pkg::*;

   opcode_t opcode;
   mem_op_t next_mem_op;
   op7_op_t next_op7_op;
   offset_t next_offset;
   logic    next_unsupported;

   assign opcode = rd_data[word_w-1 -: opcode_w];

   // ------------------------------------------------------------------
   // Decode of the word on rd_data
   // ------------------------------------------------------------------
   always_comb begin
      next_mem_op      = '0;
      next_op7_op      = '0;
      next_offset      = '0;
      next_unsupported = 1'b0;

      // Memory-reference words carry I, Z and the page address
      if (opcode <= op_jmp) begin
         next_offset = rd_data[offset_w-1:0];
      end

      case (opcode)
         op_and: next_mem_op[bit_and] = 1'b1;
         op_tad: next_mem_op[bit_tad] = 1'b1;
         op_isz: next_mem_op[bit_isz] = 1'b1;
         op_dca: next_mem_op[bit_dca] = 1'b1;
         op_jms: next_mem_op[bit_jms] = 1'b1;
         op_jmp: next_mem_op[bit_jmp] = 1'b1;

         // No IO devices here, so IOT runs as a NOP
         op_iot: begin
            next_op7_op[bit_nop] = 1'b1;
            next_unsupported     = 1'b1;
         end

         op_opr: begin
            case (rd_data)
               code_nop:     next_op7_op[bit_nop]     = 1'b1;
               code_iac:     next_op7_op[bit_iac]     = 1'b1;
               code_ral:     next_op7_op[bit_ral]     = 1'b1;
               code_rtl:     next_op7_op[bit_rtl]     = 1'b1;
               code_rar:     next_op7_op[bit_rar]     = 1'b1;
               code_rtr:     next_op7_op[bit_rtr]     = 1'b1;
               code_cml:     next_op7_op[bit_cml]     = 1'b1;
               code_cma:     next_op7_op[bit_cma]     = 1'b1;
               code_cia:     next_op7_op[bit_cia]     = 1'b1;
               code_cll:     next_op7_op[bit_cll]     = 1'b1;
               code_cla1:    next_op7_op[bit_cla1]    = 1'b1;
               code_cla_cll: next_op7_op[bit_cla_cll] = 1'b1;
               code_hlt:     next_op7_op[bit_hlt]     = 1'b1;
               code_osr:     next_op7_op[bit_osr]     = 1'b1;
               code_skp:     next_op7_op[bit_skp]     = 1'b1;
               code_snl:     next_op7_op[bit_snl]     = 1'b1;
               code_szl:     next_op7_op[bit_szl]     = 1'b1;
               code_sza:     next_op7_op[bit_sza]     = 1'b1;
               code_sna:     next_op7_op[bit_sna]     = 1'b1;
               code_sma:     next_op7_op[bit_sma]     = 1'b1;
               code_spa:     next_op7_op[bit_spa]     = 1'b1;
               code_cla2:    next_op7_op[bit_cla2]    = 1'b1;
               // Microcoded combinations outside the table
               default: begin
                  next_op7_op[bit_nop] = 1'b1;
                  next_unsupported     = 1'b1;
               end
            endcase
         end
      endcase
   end

   // ------------------------------------------------------------------
   // Output registers
   // ------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         mem_op      <= '0;
         op7_op      <= '0;
         mem_offset  <= '0;
         unsupported <= 1'b0;
         dec_valid   <= 1'b0;
      end else begin
         dec_valid <= data_valid;
         if (data_valid) begin
            mem_op      <= next_mem_op;
            op7_op      <= next_op7_op;
            mem_offset  <= next_offset;
            unsupported <= next_unsupported;
         end
      end
   end

endmodule

// File: verilog/ifd_fetch_ctrl.sv
/*
   Instruction fetch sequencer
   Issues one memory read per instruction, flags the cycle in which
   the read data is valid, then waits for the execution unit to drop
   stall before fetching from its PC. Fetching stops for good once
   the PC comes back to the start address.
*/
`timescale 1ns/100ps

module ifd_fetch_ctrl #(
   parameter pdp8_types_pkg::addr_t start_addr = 12'o200
) (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  stall,
   input  pdp8_types_pkg::addr_t pc_value,
   output logic                  rd_req,
   output pdp8_types_pkg::addr_t rd_addr,
   output logic                  data_valid
);

   import pdp8_isa_pkg::*;

   fetch_state_e state;

   // High during the cycle the decoder presents its new outputs.
   // The execution unit only reacts to stall after that cycle
   logic dec_cycle;

   // ------------------------------------------------------------------
   // Strobes decoded from the state
   // ------------------------------------------------------------------
   // Read strobe lasts exactly the one cycle spent in st_request
   assign rd_req = (state == st_request);

   // Memory answers one cycle after the request
   assign data_valid = (state == st_data);

   // ------------------------------------------------------------------
   // Sequencer
   // ------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= st_first;
         rd_addr   <= '0;
         dec_cycle <= 1'b0;
      end else begin
         case (state)
            // First instruction always comes from the start address
            st_first: begin
               rd_addr <= start_addr;
               state   <= st_request;
            end

            st_request: begin
               state <= st_data;
            end

            st_data: begin
               dec_cycle <= 1'b1;
               state     <= st_exec_wait;
            end

            st_exec_wait: begin
               if (dec_cycle) begin
                  // Let the decoded outputs be seen before sampling stall
                  dec_cycle <= 1'b0;
               end else if (!stall) begin
                  if (pc_value == start_addr) begin
                     // Program wrapped back to its entry point
                     state <= st_done;
                  end else begin
                     rd_addr <= pc_value;
                     state   <= st_request;
                  end
               end
            end

            // Only reset leaves this state
            st_done: begin
               state <= st_done;
            end

            default: begin
               state <= st_first;
            end
         endcase
      end
   end

endmodule

// File: verilog/pdp8_isa_pkg.sv
/*
   PDP-8 instruction set definitions
   Major opcodes, full-word operate codes, the bit positions of the
   one-hot decode vectors and the fetch sequencer states
*/
package pdp8_isa_pkg;

   import pdp8_types_pkg::*;

   // ------------------------------------------------------------------
   // Major opcodes
   // ------------------------------------------------------------------
   localparam opcode_t op_and = 3'o0;
   localparam opcode_t op_tad = 3'o1;
   localparam opcode_t op_isz = 3'o2;
   localparam opcode_t op_dca = 3'o3;
   localparam opcode_t op_jms = 3'o4;
   localparam opcode_t op_jmp = 3'o5;
   localparam opcode_t op_iot = 3'o6;
   localparam opcode_t op_opr = 3'o7;

   // ------------------------------------------------------------------
   // Operate microinstructions matched on the whole word
   // ------------------------------------------------------------------
   // Group 1
   localparam word_t code_nop     = 12'o7000;
   localparam word_t code_iac     = 12'o7001;
   localparam word_t code_ral     = 12'o7004;
   localparam word_t code_rtl     = 12'o7006;
   localparam word_t code_rar     = 12'o7010;
   localparam word_t code_rtr     = 12'o7012;
   localparam word_t code_cml     = 12'o7020;
   localparam word_t code_cma     = 12'o7040;
   localparam word_t code_cia     = 12'o7041;
   localparam word_t code_cll     = 12'o7100;
   localparam word_t code_cla1    = 12'o7200;
   localparam word_t code_cla_cll = 12'o7300;
   // Group 2
   localparam word_t code_hlt     = 12'o7402;
   localparam word_t code_osr     = 12'o7404;
   localparam word_t code_skp     = 12'o7410;
   localparam word_t code_snl     = 12'o7420;
   localparam word_t code_szl     = 12'o7430;
   localparam word_t code_sza     = 12'o7440;
   localparam word_t code_sna     = 12'o7450;
   localparam word_t code_sma     = 12'o7500;
   localparam word_t code_spa     = 12'o7510;
   localparam word_t code_cla2    = 12'o7600;

   // Bit positions within mem_op_t
   localparam int bit_and = 0;
   localparam int bit_tad = 1;
   localparam int bit_isz = 2;
   localparam int bit_dca = 3;
   localparam int bit_jms = 4;
   localparam int bit_jmp = 5;

   // Bit positions within op7_op_t in the order of the codes
   localparam int bit_nop     = 0;
   localparam int bit_iac     = 1;
   localparam int bit_ral     = 2;
   localparam int bit_rtl     = 3;
   localparam int bit_rar     = 4;
   localparam int bit_rtr     = 5;
   localparam int bit_cml     = 6;
   localparam int bit_cma     = 7;
   localparam int bit_cia     = 8;
   localparam int bit_cll     = 9;
   localparam int bit_cla1    = 10;
   localparam int bit_cla_cll = 11;
   localparam int bit_hlt     = 12;
   localparam int bit_osr     = 13;
   localparam int bit_skp     = 14;
   localparam int bit_snl     = 15;
   localparam int bit_szl     = 16;
   localparam int bit_sza     = 17;
   localparam int bit_sna     = 18;
   localparam int bit_sma     = 19;
   localparam int bit_spa     = 20;
   localparam int bit_cla2    = 21;

   // Fetch sequencer states
   typedef enum logic [2:0] {
      st_first,
      st_request,
      st_data,
      st_exec_wait,
      st_done
   } fetch_state_e;

endpackage

// File: verilog/pdp8_types_pkg.sv
/*
   PDP-8 data types
   Widths of the machine word, the address and the instruction fields,
   and the vector types built on them for the fetch and decode unit
*/
package pdp8_types_pkg;

   // Machine word and memory address
   localparam int word_w = 12;
   localparam int addr_w = 12;

   // Instruction fields
   // Major opcode sits in the top three bits of the word
   localparam int opcode_w = 3;
   // Page offset plus the indirect and page bits
   localparam int offset_w = 9;

   // One-hot decode vectors
   localparam int mem_op_w = 6;
   localparam int op7_op_w = 22;

   typedef logic [word_w-1:0]   word_t;
   typedef logic [addr_w-1:0]   addr_t;
   typedef logic [opcode_w-1:0] opcode_t;
   typedef logic [offset_w-1:0] offset_t;

   // One bit per memory-reference instruction from AND to JMP
   typedef logic [mem_op_w-1:0] mem_op_t;

   // One bit per supported operate microinstruction
   typedef logic [op7_op_w-1:0] op7_op_t;

endpackage
